//--- regfile_pkg.sv
// Shared widths, ALU opcodes and the packed structs used on the register
// file ports. The byte lane count assumes xlen is a multiple of 8, and
// reg_addr_w must cover num_regs.

`default_nettype none

package regfile_pkg;

    // register file geometry
    parameter int xlen       = 32;
    parameter int num_regs   = 32;
    parameter int reg_addr_w = 5;
    parameter int byte_en_w  = xlen / 8;

    // encodings 5 to 7 are unused and give a zero result
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4
    } alu_op_e;

    // one execute request, 13 bits
    typedef struct packed {
        alu_op_e               op;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
    } exec_req_t;

    // one host write into both RAM copies, 41 bits
    typedef struct packed {
        logic [reg_addr_w-1:0] addr;
        logic [byte_en_w-1:0]  byte_en;
        logic [xlen-1:0]       data;
    } reg_write_t;

    // result returned two cycles after the request
    typedef struct packed {
        logic [xlen-1:0] result;
    } exec_resp_t;

endpackage

`default_nettype wire

//--- dp_ram.sv
// Dual-port RAM with byte write enables and a registered read address.
// Read data is valid the cycle after read and follows the array, so a write
// to the same address in the same cycle is seen (write-first).
// DATAW must be a multiple of WRENW. Addresses must stay below SIZE.
// The array has no reset and no initial contents.

`timescale 1ns/100ps
`default_nettype none

module dp_ram #(
    parameter int DATAW = 32,
    parameter int SIZE  = 32,
    parameter int WRENW = 4,
    localparam int ADDRW = (SIZE > 1) ? $clog2(SIZE) : 1
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             read,
    input  wire logic             write,
    input  wire logic [WRENW-1:0] wren,
    input  wire logic [ADDRW-1:0] waddr,
    input  wire logic [ADDRW-1:0] raddr,
    input  wire logic [DATAW-1:0] wdata,
    output logic      [DATAW-1:0] rdata
);

    // width of one write lane
    localparam int WSELW = DATAW / WRENW;

    logic [DATAW-1:0] ram [SIZE];
    logic [DATAW-1:0] wdata_merged;
    logic [ADDRW-1:0] raddr_q;

    // old word with the enabled lanes replaced by the new data
    always_comb begin
        wdata_merged = ram[waddr];
        for (int i = 0; i < WRENW; i++) begin
            if (wren[i]) begin
                wdata_merged[i*WSELW +: WSELW] = wdata[i*WSELW +: WSELW];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            ram[waddr] <= wdata_merged;
        end
    end

    // the address holds between reads, so rdata keeps tracking that word
    always_ff @(posedge clk) begin
        if (reset) begin
            raddr_q <= '0;
        end else if (read) begin
            raddr_q <= raddr;
        end
    end

    assign rdata = ram[raddr_q];

endmodule

`default_nettype wire

//--- operand_exec.sv
// Operand stage behind the two RAM read ports. The request is held one cycle
// to line up with the RAM read data, then the ALU result is registered.
// Fixed latency of two cycles, one item per stage, no back-pressure.
// Register 0 reads as zero whatever the RAM holds at that address.

`timescale 1ns/100ps
`default_nettype none

module operand_exec (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      ex_valid,
    input  wire regfile_pkg::exec_req_t    ex_req,
    input  wire logic [regfile_pkg::xlen-1:0] rs1_data,
    input  wire logic [regfile_pkg::xlen-1:0] rs2_data,
    output logic                           res_valid,
    output regfile_pkg::exec_resp_t        res
);

    // first stage, in step with the RAM read address registers
    logic                   req_valid_q;
    regfile_pkg::exec_req_t req_q;

    // operands after the zero-register rule
    logic [regfile_pkg::xlen-1:0] op_a;
    logic [regfile_pkg::xlen-1:0] op_b;
    logic [regfile_pkg::xlen-1:0] alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            req_q <= ex_req;
        end
    end

    assign op_a = (req_q.rs1 == '0) ? '0 : rs1_data;
    assign op_b = (req_q.rs2 == '0) ? '0 : rs2_data;

    always_comb begin
        case (req_q.op)
            regfile_pkg::op_add: alu_result = op_a + op_b;
            // wraps modulo 2^xlen like the add
            regfile_pkg::op_sub: alu_result = op_a - op_b;
            regfile_pkg::op_and: alu_result = op_a & op_b;
            regfile_pkg::op_or:  alu_result = op_a | op_b;
            regfile_pkg::op_xor: alu_result = op_a ^ op_b;
            default:             alu_result = '0;
        endcase
    end

    // second stage, res_valid pulses for one cycle per request
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req_valid_q;
        end
    end

    // result holds its last value between strobes
    always_ff @(posedge clk) begin
        if (req_valid_q) begin
            res.result <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- regfile_exec_top.sv
// Register file read stage with an ALU on the two source operands.
// Two RAM copies give the two read ports. A host write goes to both copies
// in the same cycle. Results appear two cycles after ex_valid, in order.
// There is no writeback and no hazard check between writes and requests.

`timescale 1ns/100ps
`default_nettype none

module regfile_exec_top (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    wr_valid,
    input  wire regfile_pkg::reg_write_t wr,
    input  wire logic                    ex_valid,
    input  wire regfile_pkg::exec_req_t  ex_req,
    output logic                         res_valid,
    output regfile_pkg::exec_resp_t      res
);

    logic [regfile_pkg::xlen-1:0] rs1_data;
    logic [regfile_pkg::xlen-1:0] rs2_data;

    // copy a serves rs1
    dp_ram #(
        .DATAW (regfile_pkg::xlen),
        .SIZE  (regfile_pkg::num_regs),
        .WRENW (regfile_pkg::byte_en_w)
    ) u_ram_rs1 (
        .clk   (clk),
        .reset (reset),
        .read  (ex_valid),
        .write (wr_valid),
        .wren  (wr.byte_en),
        .waddr (wr.addr),
        .raddr (ex_req.rs1),
        .wdata (wr.data),
        .rdata (rs1_data)
    );

    // copy b serves rs2 and always receives the same writes as copy a
    dp_ram #(
        .DATAW (regfile_pkg::xlen),
        .SIZE  (regfile_pkg::num_regs),
        .WRENW (regfile_pkg::byte_en_w)
    ) u_ram_rs2 (
        .clk   (clk),
        .reset (reset),
        .read  (ex_valid),
        .write (wr_valid),
        .wren  (wr.byte_en),
        .waddr (wr.addr),
        .raddr (ex_req.rs2),
        .wdata (wr.data),
        .rdata (rs2_data)
    );

    operand_exec u_exec (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_req    (ex_req),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- tb_regfile_exec.sv
// Testbench for regfile_exec_top. Commands and expected results come from
// regfile_input.txt, which is read from the directory the simulation runs in.
// A result is checked when res_valid is seen, so results must come back in
// request order. Each wait gives up after 50 cycles.

`timescale 1ns/100ps
`default_nettype none

module tb_regfile_exec;

    localparam string INPUT_FILE = "regfile_input.txt";
    localparam int    RESULT_TIMEOUT = 50;

    logic                    clk;
    logic                    reset;
    logic                    wr_valid;
    regfile_pkg::reg_write_t wr;
    logic                    ex_valid;
    regfile_pkg::exec_req_t  ex_req;
    logic                    res_valid;
    regfile_pkg::exec_resp_t res;

    // expected results still in flight, oldest first
    string                        name_q[$];
    logic [regfile_pkg::xlen-1:0] exp_q[$];

    int test_count;
    int pass_count;
    int fail_count;
    logic in_batch;
    logic wr_pending;

    integer                               fd;
    int                                   rc;
    logic [8*32-1:0]                      tok;
    logic [8*32-1:0]                      name_tok;
    logic [8*32-1:0]                      op_tok;
    logic [8*256-1:0]                     rest;
    logic [regfile_pkg::reg_addr_w-1:0]   addr_in;
    logic [regfile_pkg::reg_addr_w-1:0]   rs1_in;
    logic [regfile_pkg::reg_addr_w-1:0]   rs2_in;
    logic [regfile_pkg::byte_en_w-1:0]    be_in;
    logic [regfile_pkg::xlen-1:0]         data_in;
    logic [regfile_pkg::xlen-1:0]         exp_in;
    regfile_pkg::alu_op_e                 op_in;
    logic                                 op_ok;

    regfile_exec_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr        (wr),
        .ex_valid  (ex_valid),
        .ex_req    (ex_req),
        .res_valid (res_valid),
        .res       (res)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // %s fills a vector from the right, so skip the zero bytes on the left
    function automatic string tok_to_str(input logic [8*32-1:0] t);
        string s;
        s = "";
        for (int i = 31; i >= 0; i--) begin
            if (t[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", t[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    task automatic parse_op(input logic [8*32-1:0] t, output regfile_pkg::alu_op_e op,
                            output logic ok);
        ok = 1'b1;
        case (t)
            "add": op = regfile_pkg::op_add;
            "sub": op = regfile_pkg::op_sub;
            "and": op = regfile_pkg::op_and;
            "or":  op = regfile_pkg::op_or;
            "xor": op = regfile_pkg::op_xor;
            default: begin
                op = regfile_pkg::op_add;
                ok = 1'b0;
            end
        endcase
    endtask

    // advance one clock and drop the one-cycle strobes
    task automatic next_cycle();
        @(posedge clk);
        #1;
        wr_valid   = 1'b0;
        ex_valid   = 1'b0;
        wr_pending = 1'b0;
    endtask

    task automatic check_result(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) begin
            pass_count++;
            $display("ok     %s  result %h", name, actual);
        end else begin
            fail_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < RESULT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_q.size() > 0) begin
            foreach (name_q[i]) begin
                $display("timeout: test %s got no result within %0d cycles",
                         name_q[i], RESULT_TIMEOUT);
            end
            fail_count += exp_q.size();
            name_q.delete();
            exp_q.delete();
        end
    endtask

    // inside a batch a write shares its cycle with the next request
    task automatic apply_write(input logic [4:0] a, input logic [3:0] be,
                               input logic [31:0] d);
        wr_valid     = 1'b1;
        wr.addr      = a;
        wr.byte_en   = be;
        wr.data      = d;
        if (in_batch) begin
            wr_pending = 1'b1;
        end else begin
            next_cycle();
        end
    endtask

    task automatic issue_exec(input string name, input regfile_pkg::alu_op_e op,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [31:0] expected);
        ex_valid   = 1'b1;
        ex_req.op  = op;
        ex_req.rs1 = rs1;
        ex_req.rs2 = rs2;
        name_q.push_back(name);
        exp_q.push_back(expected);
        test_count++;
        next_cycle();
        if (!in_batch) begin
            wait_results();
        end
    endtask

    always @(negedge clk) begin
        if (!reset && res_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("result %h arrived with no request outstanding", res.result);
            end else begin
                check_result(name_q.pop_front(), exp_q.pop_front(), res.result);
            end
        end
    end

    initial begin
        reset      = 1'b1;
        wr_valid   = 1'b0;
        wr         = '0;
        ex_valid   = 1'b0;
        ex_req     = '0;
        test_count = 0;
        pass_count = 0;
        fail_count = 0;
        in_batch   = 1'b0;
        wr_pending = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            fail_count++;
            $display("could not open %s", INPUT_FILE);
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    rc = $fgets(rest, fd);
                end else if (tok == "W") begin
                    rc = $fscanf(fd, "%h %h %h", addr_in, be_in, data_in);
                    if (rc == 3) begin
                        apply_write(addr_in, be_in, data_in);
                    end else begin
                        fail_count++;
                        $display("a write line in %s has missing fields", INPUT_FILE);
                    end
                end else if (tok == "X") begin
                    rc = $fscanf(fd, "%s %s %h %h %h", name_tok, op_tok, rs1_in, rs2_in,
                                 exp_in);
                    if (rc != 5) begin
                        fail_count++;
                        $display("an execute line in %s has missing fields", INPUT_FILE);
                    end else begin
                        parse_op(op_tok, op_in, op_ok);
                        if (op_ok) begin
                            issue_exec(tok_to_str(name_tok), op_in, rs1_in, rs2_in,
                                       exp_in);
                        end else begin
                            fail_count++;
                            $display("test %s names an unknown operation %s",
                                     tok_to_str(name_tok), tok_to_str(op_tok));
                        end
                    end
                end else if (tok == "B") begin
                    if (in_batch) begin
                        if (wr_pending) begin
                            next_cycle();
                        end
                        in_batch = 1'b0;
                        wait_results();
                    end else begin
                        in_batch = 1'b1;
                    end
                end else begin
                    fail_count++;
                    $display("unknown command %s in %s", tok_to_str(tok), INPUT_FILE);
                end
            end
            $fclose(fd);
        end
        wait_results();

        $display("tests %0d, passed %0d, failed %0d", test_count, pass_count, fail_count);
        if (fail_count == 0 && pass_count == test_count && test_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- regfile_input.txt
# W addr byte_en data | X name op rs1 rs2 expected | all numbers in hex
# B opens or closes a batch issued in consecutive cycles, a W in a batch shares the next X's cycle
W 01 f 00000005
W 02 f 00000003
W 03 f 12345678
W 04 f 0f0f0f0f
W 05 f ffffffff
W 06 f 80000000
# lanes 0 and 2 of register 7, lane 3 of register 8
W 07 f aabbccdd
W 07 5 11223344
W 08 f 01020304
W 08 8 ff000000
# register 0 must ignore this
W 00 f deadbeef
W 0b f 11111111
X add_basic add 01 02 00000008
X add_wrap add 05 02 00000002
X sub_basic sub 03 01 12345673
X sub_wrap sub 02 01 fffffffe
X and_mask and 03 04 02040608
X or_mix or 04 06 8f0f0f0f
X xor_mix xor 03 05 edcba987
X xor_self xor 03 03 00000000
X byte_lanes_0_2 or 07 00 aa22cc44
X byte_lane_3 or 00 08 ff020304
X zero_reg add 00 00 00000000
X zero_rs2 sub 01 00 00000005
# write and read of the same register in one cycle
B
W 09 f 00000010
X wf_full add 09 01 00000015
W 0b 2 0000ee00
X wf_byte or 0b 00 1111ee11
B
# one request per cycle
B
X b2b_add add 01 03 1234567d
X b2b_sub sub 06 02 7ffffffd
X b2b_and and 05 07 aa22cc44
X b2b_or or 01 02 00000007
X b2b_xor xor 04 05 f0f0f0f0
X b2b_zero xor 00 03 12345678
B

//--- project.f
regfile_pkg.sv
dp_ram.sv
operand_exec.sv
regfile_exec_top.sv
tb_regfile_exec.sv

//--- Makefile
# Verilator flow for the register file operand stage.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
FILELIST   ?= project.f
TOP        ?= tb_regfile_exec
RTL_TOP    ?= regfile_exec_top
RTL_SRCS   ?= regfile_pkg.sv dp_ram.sv operand_exec.sv regfile_exec_top.sv
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the verdict, a crash also fails through the missing binary or exit code
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
